/* verilog/turf_reg_pkg.sv */
`default_nettype none

package turf_reg_pkg;

    ////////////////////////////////////////////////////////////
    // bus and link widths
    ////////////////////////////////////////////////////////////

    localparam int WB_ADDR_W    = 28;
    localparam int WB_DATA_W    = 32;
    localparam int NUM_LINKS    = 4;
    localparam int LINK_W       = 2;
    localparam int CRATE_ADDR_W = 25;

    // top address bit picks the crate space and the next two the link
    localparam int CRATE_SEL_BIT = WB_ADDR_W - 1;
    localparam int LINK_LSB      = CRATE_ADDR_W;

    // ID space offsets
    localparam int ID_OFFS_W      = 3;
    localparam int STATUS_INV_LSB = 8;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

    typedef enum logic [1:0] {
        CMD_WRITE = 2'd0,
        CMD_READ  = 2'd1
    } cmd_op_e;

    typedef enum logic [ID_OFFS_W-1:0] {
        REG_IDENT       = 3'd0,
        REG_DATEVERSION = 3'd1,
        REG_BRIDGE_TYPE = 3'd2,
        REG_STATUS      = 3'd3,
        REG_LINK_UP     = 3'd4
    } id_reg_e;

    // returned by a read that failed validity or timed out
    localparam logic [WB_DATA_W-1:0] BRIDGE_BAD_DATA = 32'hDEADDEAD;

    // opcode, link, remote address, write data
    localparam int CMD_ENTRY_W = 2 + LINK_W + CRATE_ADDR_W + WB_DATA_W;

endpackage

`default_nettype wire

/* verilog/turf_intercon.sv */
`default_nettype none

module turf_intercon import turf_reg_pkg::*; (
    input  wire                   wb_cyc_i,
    input  wire                   wb_stb_i,
    input  wire                   wb_we_i,
    input  wire [WB_ADDR_W-1:0]   wb_adr_i,
    input  wire [WB_DATA_W-1:0]   wb_dat_i,
    output logic [WB_DATA_W-1:0]  wb_dat_o,
    output logic                  wb_ack_o,
    // ID/control space
    output logic                  idc_stb_o,
    input  wire                   idc_ack_i,
    input  wire [WB_DATA_W-1:0]   idc_dat_i,
    // crate space
    output logic                  cr_stb_o,
    input  wire                   cr_ack_i,
    input  wire [WB_DATA_W-1:0]   cr_dat_i,
    // request shared by both slaves
    output logic [WB_ADDR_W-1:0]  sl_adr_o,
    output logic                  sl_we_o,
    output logic [WB_DATA_W-1:0]  sl_dat_o
);

    logic req;
    logic cr_sel;

    assign req    = wb_cyc_i && wb_stb_i;
    assign cr_sel = wb_adr_i[CRATE_SEL_BIT];

    // only the addressed space sees a strobe
    assign idc_stb_o = req && !cr_sel;
    assign cr_stb_o  = req && cr_sel;

    assign sl_adr_o = wb_adr_i;
    assign sl_we_o  = wb_we_i;
    assign sl_dat_o = wb_dat_i;

    // return path follows the held address
    always_comb begin
        if (cr_sel) begin
            wb_ack_o = cr_ack_i;
            wb_dat_o = cr_dat_i;
        end else begin
            wb_ack_o = idc_ack_i;
            wb_dat_o = idc_dat_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/turf_id_ctrl.sv */
`default_nettype none

module turf_id_ctrl import turf_reg_pkg::*; #(
    parameter logic [WB_DATA_W-1:0] IDENT       = "TURF",
    parameter logic [WB_DATA_W-1:0] DATEVERSION = 32'h0000_0000
) (
    input  wire                     ps_clk,
    input  wire                     reset_i,
    input  wire                     stb_i,
    input  wire                     we_i,
    input  wire [WB_ADDR_W-1:0]     adr_i,
    input  wire [WB_DATA_W-1:0]     dat_i,
    output logic [WB_DATA_W-1:0]    dat_o,
    output logic                    ack_o,
    input  wire [NUM_LINKS-1:0]     link_up_i,
    input  wire [NUM_LINKS-1:0]     timeout_pulse_i,
    input  wire [NUM_LINKS-1:0]     invalid_pulse_i,
    output logic [2*NUM_LINKS-1:0]  bridge_type_o
);

    logic                   offs_hit;
    id_reg_e                offs;
    logic                   access;
    logic                   status_clr;
    logic [NUM_LINKS-1:0]   timeout_q;
    logic [NUM_LINKS-1:0]   invalid_q;
    logic [WB_DATA_W-1:0]   rd_data;

    // anything beyond the low offsets reads zero
    assign offs_hit = (adr_i[WB_ADDR_W-1:ID_OFFS_W] == '0);
    assign offs     = id_reg_e'(adr_i[ID_OFFS_W-1:0]);
    assign access   = stb_i && !ack_o;

    assign status_clr = access && we_i && offs_hit && (offs == REG_STATUS);

    always_comb begin
        rd_data = '0;
        if (offs_hit) begin
            case (offs)
                REG_IDENT:       rd_data = IDENT;
                REG_DATEVERSION: rd_data = DATEVERSION;
                REG_BRIDGE_TYPE: rd_data[2*NUM_LINKS-1:0] = bridge_type_o;
                REG_STATUS: begin
                    rd_data[NUM_LINKS-1:0] = timeout_q;
                    rd_data[STATUS_INV_LSB +: NUM_LINKS] = invalid_q;
                end
                REG_LINK_UP:     rd_data[NUM_LINKS-1:0] = link_up_i;
                default:         rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            ack_o         <= 1'b0;
            bridge_type_o <= '0;
            timeout_q     <= '0;
            invalid_q     <= '0;
        end else begin
            ack_o <= access;
            if (access && we_i && offs_hit && offs == REG_BRIDGE_TYPE) begin
                bridge_type_o <= dat_i[2*NUM_LINKS-1:0];
            end
            // new pulse beats a simultaneous clear
            timeout_q <= (timeout_q & ~({NUM_LINKS{status_clr}} & dat_i[NUM_LINKS-1:0]))
                         | timeout_pulse_i;
            invalid_q <= (invalid_q
                          & ~({NUM_LINKS{status_clr}} & dat_i[STATUS_INV_LSB +: NUM_LINKS]))
                         | invalid_pulse_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (access) begin
            dat_o <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/crate_bridge.sv */
`default_nettype none

module crate_bridge import turf_reg_pkg::*; #(
    parameter int BRIDGE_TIMEOUT = 64
) (
    input  wire                     ps_clk,
    input  wire                     reset_i,
    input  wire                     stb_i,
    input  wire                     we_i,
    input  wire [WB_ADDR_W-1:0]     adr_i,
    input  wire [WB_DATA_W-1:0]     dat_i,
    output logic [WB_DATA_W-1:0]    dat_o,
    output logic                    ack_o,
    input  wire [2*NUM_LINKS-1:0]   bridge_type_i,
    input  wire [NUM_LINKS-1:0]     link_up_i,
    input  wire                     fifo_full_i,
    output logic                    push_o,
    output logic [CMD_ENTRY_W-1:0]  entry_o,
    input  wire                     resp_valid_i,
    input  wire [WB_DATA_W-1:0]     resp_data_i,
    input  wire [LINK_W-1:0]        resp_link_i,
    output logic [NUM_LINKS-1:0]    timeout_pulse_o,
    output logic [NUM_LINKS-1:0]    invalid_pulse_o
);

    localparam int TMO_W = $clog2(BRIDGE_TIMEOUT + 1);

    typedef enum logic [1:0] {IDLE, PUSH, WAIT_RESP, ACK} state_e;

    state_e                  state;
    cmd_op_e                 op_q;
    logic [LINK_W-1:0]       link_q;
    logic [CRATE_ADDR_W-1:0] addr_q;
    logic [WB_DATA_W-1:0]    wdata_q;
    logic [WB_DATA_W-1:0]    rdata_q;
    logic [TMO_W-1:0]        tmo_cnt;

    logic [LINK_W-1:0]       req_link;
    bridge_type_e            req_type;
    logic                    req_valid;

    ////////////////////////////////////////////////////////////
    // per-link type lookup and validity
    ////////////////////////////////////////////////////////////

    assign req_link  = adr_i[LINK_LSB +: LINK_W];
    assign req_type  = bridge_type_e'(bridge_type_i[req_link*2 +: 2]);
    // reserved types never valid, aurora only while up
    assign req_valid = (req_type == BRIDGE_AURORA) && link_up_i[req_link];

    assign push_o  = (state == PUSH) && !fifo_full_i;
    assign entry_o = {op_q, link_q, addr_q, wdata_q};
    assign ack_o   = (state == ACK);
    assign dat_o   = rdata_q;

    always_ff @(posedge ps_clk) begin
        timeout_pulse_o <= '0;
        invalid_pulse_o <= '0;
        if (reset_i) begin
            state   <= IDLE;
            tmo_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (stb_i) begin
                        op_q    <= we_i ? CMD_WRITE : CMD_READ;
                        link_q  <= req_link;
                        addr_q  <= adr_i[CRATE_ADDR_W-1:0];
                        wdata_q <= dat_i;
                        if (req_type == BRIDGE_NONE) begin
                            rdata_q <= '0;
                            state   <= ACK;
                        end else if (!req_valid) begin
                            rdata_q <= BRIDGE_BAD_DATA;
                            invalid_pulse_o[req_link] <= 1'b1;
                            state   <= ACK;
                        end else begin
                            state <= PUSH;
                        end
                    end
                end
                // wait out a full FIFO
                PUSH: begin
                    if (!fifo_full_i) begin
                        tmo_cnt <= '0;
                        state   <= (op_q == CMD_WRITE) ? ACK : WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (resp_valid_i && resp_link_i == link_q) begin
                        rdata_q <= resp_data_i;
                        state   <= ACK;
                    end else if (tmo_cnt == TMO_W'(BRIDGE_TIMEOUT - 1)) begin
                        rdata_q <= BRIDGE_BAD_DATA;
                        timeout_pulse_o[link_q] <= 1'b1;
                        state   <= ACK;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                ACK: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/cmd_fifo.sv */
`default_nettype none

module cmd_fifo import turf_reg_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                     ps_clk,
    input  wire                     reset_i,
    input  wire                     push_i,
    input  wire [CMD_ENTRY_W-1:0]   entry_i,
    output logic                    full_o,
    output logic                    valid_o,
    input  wire                     pop_i,
    output logic [CMD_ENTRY_W-1:0]  entry_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CMD_ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   do_push;
    logic                   do_pop;

    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign valid_o = (count != '0);
    assign entry_o = mem[rd_ptr];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at the depth, not the power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge ps_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/cmd_sender.sv */
`default_nettype none

module cmd_sender import turf_reg_pkg::*; (
    input  wire                     ps_clk,
    input  wire                     reset_i,
    input  wire                     fifo_valid_i,
    input  wire [CMD_ENTRY_W-1:0]   fifo_entry_i,
    output logic                    fifo_pop_o,
    output logic                    cmd_valid_o,
    input  wire                     cmd_ready_i,
    output logic [WB_DATA_W-1:0]    cmd_data_o,
    output logic [LINK_W-1:0]       cmd_dest_o,
    output logic                    cmd_last_o
);

    // in HEADER any beat on show is the last of its command
    // in DATA the header is on show and the data beat follows
    typedef enum logic {HEADER, DATA} state_e;

    state_e                  state;
    cmd_op_e                 e_op;
    logic [LINK_W-1:0]       e_link;
    logic [CRATE_ADDR_W-1:0] e_addr;
    logic [WB_DATA_W-1:0]    e_data;
    logic [WB_DATA_W-1:0]    wdata_q;

    assign {e_op, e_link, e_addr, e_data} = fifo_entry_i;

    assign fifo_pop_o = (state == HEADER) && fifo_valid_i && (!cmd_valid_o || cmd_ready_i);

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state       <= HEADER;
            cmd_valid_o <= 1'b0;
        end else if (state == DATA) begin
            if (cmd_ready_i) begin
                cmd_data_o <= wdata_q;
                cmd_last_o <= 1'b1;
                state      <= HEADER;
            end
        end else if (fifo_pop_o) begin
            cmd_valid_o <= 1'b1;
            cmd_data_o  <= {e_op, 5'b00000, e_addr};
            cmd_dest_o  <= e_link;
            cmd_last_o  <= (e_op == CMD_READ);
            wdata_q     <= e_data;
            if (e_op == CMD_WRITE) begin
                state <= DATA;
            end
        end else if (cmd_ready_i) begin
            cmd_valid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/turf_reg_top.sv */
`default_nettype none

module turf_reg_top import turf_reg_pkg::*; #(
    parameter logic [WB_DATA_W-1:0] IDENT       = "TURF",
    parameter logic [WB_DATA_W-1:0] DATEVERSION = 32'h0000_0000,
    parameter int                   BRIDGE_TIMEOUT = 64,
    parameter int                   FIFO_DEPTH     = 4
) (
    input  wire                    ps_clk,
    input  wire                    reset_i,
    input  wire                    wb_cyc_i,
    input  wire                    wb_stb_i,
    input  wire                    wb_we_i,
    input  wire [WB_ADDR_W-1:0]    wb_adr_i,
    input  wire [WB_DATA_W-1:0]    wb_dat_i,
    output logic [WB_DATA_W-1:0]   wb_dat_o,
    output logic                   wb_ack_o,
    input  wire [NUM_LINKS-1:0]    link_up_i,
    output logic                   cmd_valid_o,
    input  wire                    cmd_ready_i,
    output logic [WB_DATA_W-1:0]   cmd_data_o,
    output logic [LINK_W-1:0]      cmd_dest_o,
    output logic                   cmd_last_o,
    input  wire                    resp_valid_i,
    input  wire [WB_DATA_W-1:0]    resp_data_i,
    input  wire [LINK_W-1:0]       resp_link_i
);

    // shared request toward both spaces
    logic                   sl_we;
    logic [WB_ADDR_W-1:0]   sl_adr;
    logic [WB_DATA_W-1:0]   sl_dat;

    logic                   idc_stb;
    logic                   idc_ack;
    logic [WB_DATA_W-1:0]   idc_dat;
    logic                   cr_stb;
    logic                   cr_ack;
    logic [WB_DATA_W-1:0]   cr_dat;

    logic [2*NUM_LINKS-1:0] bridge_type;
    logic [NUM_LINKS-1:0]   timeout_pulse;
    logic [NUM_LINKS-1:0]   invalid_pulse;

    // command path
    logic                   fifo_push;
    logic                   fifo_full;
    logic [CMD_ENTRY_W-1:0] push_entry;
    logic                   fifo_valid;
    logic                   fifo_rd;
    logic [CMD_ENTRY_W-1:0] fifo_entry;

    turf_intercon u_intercon (
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .idc_stb_o(idc_stb), .idc_ack_i(idc_ack), .idc_dat_i(idc_dat),
        .cr_stb_o(cr_stb), .cr_ack_i(cr_ack), .cr_dat_i(cr_dat),
        .sl_adr_o(sl_adr), .sl_we_o(sl_we), .sl_dat_o(sl_dat)
    );

    turf_id_ctrl #(.IDENT(IDENT), .DATEVERSION(DATEVERSION)) u_id_ctrl (
        .ps_clk(ps_clk), .reset_i(reset_i),
        .stb_i(idc_stb), .we_i(sl_we), .adr_i(sl_adr), .dat_i(sl_dat),
        .dat_o(idc_dat), .ack_o(idc_ack),
        .link_up_i(link_up_i),
        .timeout_pulse_i(timeout_pulse), .invalid_pulse_i(invalid_pulse),
        .bridge_type_o(bridge_type)
    );

    crate_bridge #(.BRIDGE_TIMEOUT(BRIDGE_TIMEOUT)) u_bridge (
        .ps_clk(ps_clk), .reset_i(reset_i),
        .stb_i(cr_stb), .we_i(sl_we), .adr_i(sl_adr), .dat_i(sl_dat),
        .dat_o(cr_dat), .ack_o(cr_ack),
        .bridge_type_i(bridge_type), .link_up_i(link_up_i),
        .fifo_full_i(fifo_full), .push_o(fifo_push), .entry_o(push_entry),
        .resp_valid_i(resp_valid_i), .resp_data_i(resp_data_i),
        .resp_link_i(resp_link_i),
        .timeout_pulse_o(timeout_pulse), .invalid_pulse_o(invalid_pulse)
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .ps_clk(ps_clk), .reset_i(reset_i),
        .push_i(fifo_push), .entry_i(push_entry), .full_o(fifo_full),
        .valid_o(fifo_valid), .pop_i(fifo_rd), .entry_o(fifo_entry)
    );

    cmd_sender u_sender (
        .ps_clk(ps_clk), .reset_i(reset_i),
        .fifo_valid_i(fifo_valid), .fifo_entry_i(fifo_entry), .fifo_pop_o(fifo_rd),
        .cmd_valid_o(cmd_valid_o), .cmd_ready_i(cmd_ready_i),
        .cmd_data_o(cmd_data_o), .cmd_dest_o(cmd_dest_o), .cmd_last_o(cmd_last_o)
    );

endmodule

`default_nettype wire

/* tb/turf_reg_checker.sv */
`default_nettype none

module turf_reg_checker import turf_reg_pkg::*; (
    input wire                 ps_clk,
    input wire                 reset_i,
    input wire                 wb_cyc_i,
    input wire                 wb_stb_i,
    input wire                 wb_ack_i,
    input wire                 cmd_valid_i,
    input wire                 cmd_ready_i,
    input wire [WB_DATA_W-1:0] cmd_data_i,
    input wire [LINK_W-1:0]    cmd_dest_i,
    input wire                 cmd_last_i
);

    int fail_count = 0;

    // Wishbone ack rules
    ack_needs_request: assert property (@(posedge ps_clk) disable iff (reset_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
        $error("ack seen without cyc and stb");
        fail_count++;
    end

    ack_single_cycle: assert property (@(posedge ps_clk) disable iff (reset_i)
        wb_ack_i |=> !wb_ack_i)
    else begin
        $error("ack lasted more than one cycle");
        fail_count++;
    end

    // held beat under back-pressure
    beat_stable: assert property (@(posedge ps_clk) disable iff (reset_i)
        (cmd_valid_i && !cmd_ready_i) |=>
            (cmd_valid_i && $stable(cmd_data_i) && $stable(cmd_dest_i) && $stable(cmd_last_i)))
    else begin
        $error("command beat changed before transfer");
        fail_count++;
    end

    no_beat_from_reset: assert property (@(posedge ps_clk) reset_i |=> !cmd_valid_i)
    else begin
        $error("command valid high right after reset");
        fail_count++;
    end

endmodule

bind turf_reg_top turf_reg_checker u_checker (
    .ps_clk(ps_clk), .reset_i(reset_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_i(wb_ack_o),
    .cmd_valid_i(cmd_valid_o), .cmd_ready_i(cmd_ready_i),
    .cmd_data_i(cmd_data_o), .cmd_dest_i(cmd_dest_o), .cmd_last_i(cmd_last_o)
);

`default_nettype wire

/* tb/tb_turf_reg.sv */
`default_nettype none

module tb_turf_reg;

    localparam logic [31:0] EXP_IDENT   = "TURF";
    localparam logic [31:0] EXP_DATEVER = 32'h80F1_0410;
    localparam logic [31:0] BAD_DATA    = 32'hDEAD_DEAD;
    localparam logic [31:0] RESP_XOR    = 32'hC0DE_0000;
    localparam logic [1:0]  OP_WRITE    = 2'b00;
    localparam logic [1:0]  OP_READ     = 2'b01;
    localparam int          WAIT_LIMIT  = 300;

    logic        ps_clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [27:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [3:0]  link_up;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [31:0] cmd_data;
    logic [1:0]  cmd_dest;
    logic        cmd_last;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic [1:0]  resp_link;

    integer      seed;
    int          mismatches;
    int          timeouts;
    int          other_errors;
    int          resp_wait;
    logic [31:0] resp_addr_q;
    logic [1:0]  resp_link_q;
    logic        responder_on;
    // next stream beat opens a command
    logic        beat_is_header;
    // expected beats as {dest, last, data}
    logic [34:0] exp_beats[$];

    turf_reg_top #(.DATEVERSION(EXP_DATEVER)) dut0 (
        .ps_clk(ps_clk), .reset_i(reset),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
        .link_up_i(link_up),
        .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready),
        .cmd_data_o(cmd_data), .cmd_dest_o(cmd_dest), .cmd_last_o(cmd_last),
        .resp_valid_i(resp_valid), .resp_data_i(resp_data), .resp_link_i(resp_link)
    );

    always #10 ps_clk = ~ps_clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    function automatic logic [27:0] crate_adr(input logic [1:0] link, input logic [24:0] addr);
        return {1'b1, link, addr};
    endfunction

    // one Wishbone classic access, held until ack
    task automatic bus_access(input logic we, input logic [27:0] adr,
                              input logic [31:0] wdata, output logic [31:0] data);
        int n;
        n = 0;
        data = '0;
        @(posedge ps_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge ps_clk);
            n++;
        end while (!wb_ack && n < WAIT_LIMIT);
        if (wb_ack) begin
            data = wb_dat_r;
        end else begin
            $display("timeout: no Wishbone ack for address %h at time %0t", adr, $time);
            timeouts++;
        end
        @(posedge ps_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic reg_write(input logic [27:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic reg_read_expect(input logic [27:0] adr, input logic [31:0] exp,
                                   input string name);
        logic [31:0] data;
        bus_access(1'b0, adr, 32'h0, data);
        check_value(name, data, exp);
    endtask

    task automatic crate_write(input logic [1:0] link, input logic [24:0] addr,
                               input logic [31:0] data, input logic beats_due);
        if (beats_due) begin
            exp_beats.push_back({link, 1'b0, OP_WRITE, 5'b00000, addr});
            exp_beats.push_back({link, 1'b1, data});
        end
        reg_write(crate_adr(link, addr), data);
    endtask

    task automatic crate_read_expect(input logic [1:0] link, input logic [24:0] addr,
                                     input logic beat_due, input logic [31:0] exp,
                                     input string name);
        if (beat_due) begin
            exp_beats.push_back({link, 1'b1, OP_READ, 5'b00000, addr});
        end
        reg_read_expect(crate_adr(link, addr), exp, name);
    endtask

    task automatic wait_stream_drain();
        int n;
        n = 0;
        while (exp_beats.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge ps_clk);
            n++;
        end
        if (exp_beats.size() != 0) begin
            $display("timeout: %0d expected command beats never came out", exp_beats.size());
            timeouts++;
            exp_beats.delete();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stream monitor and link responder
    ////////////////////////////////////////////////////////////

    // a beat seen here transfers on the next rising edge
    always @(negedge ps_clk) begin : stream_monitor
        logic [34:0] exp;
        if (!reset && cmd_valid && cmd_ready) begin
            if (exp_beats.size() == 0) begin
                $display("unexpected command beat to link %0d at time %0t", cmd_dest, $time);
                other_errors++;
            end else begin
                exp = exp_beats.pop_front();
                check_value("cmd_data_o", cmd_data, exp[31:0]);
                check_value("cmd_dest_o", 32'(cmd_dest), 32'(exp[34:33]));
                check_value("cmd_last_o", 32'(cmd_last), 32'(exp[32]));
            end
            if (responder_on && beat_is_header && cmd_data[31:30] == OP_READ) begin
                resp_wait   = 1 + ($random(seed) & 7);
                resp_addr_q = {7'b0, cmd_data[24:0]};
                resp_link_q = cmd_dest;
            end
            beat_is_header = cmd_last;
        end
    end

    always @(posedge ps_clk) begin
        resp_valid <= 1'b0;
        if (resp_wait > 0) begin
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                resp_valid <= 1'b1;
                resp_data  <= resp_addr_q ^ RESP_XOR;
                resp_link  <= resp_link_q;
            end
        end
        cmd_ready <= 1'($random(seed));
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed           = 63;
        ps_clk         = 1'b0;
        reset          = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        link_up        = 4'b1011;
        cmd_ready      = 1'b0;
        resp_valid     = 1'b0;
        resp_data      = '0;
        resp_link      = '0;
        mismatches     = 0;
        timeouts       = 0;
        other_errors   = 0;
        resp_wait      = 0;
        responder_on   = 1'b1;
        beat_is_header = 1'b1;
        repeat (5) @(posedge ps_clk);
        reset <= 1'b0;

        // ID space
        reg_read_expect(28'd0, EXP_IDENT, "ident");
        reg_read_expect(28'd1, EXP_DATEVER, "dateversion");
        reg_read_expect(28'd4, 32'h0000_000B, "link up");
        reg_read_expect(28'd5, 32'h0, "unused offset");
        reg_read_expect(28'h000_0040, 32'h0, "offset beyond map");
        // links 0 and 3 aurora, link 1 reserved, link 2 none
        reg_write(28'd2, 32'h0000_004D);
        reg_read_expect(28'd2, 32'h0000_004D, "bridge type");

        // crate writes under random back-pressure
        crate_write(2'd0, 25'h012_3456, 32'hA5A5_0001, 1'b1);
        wait_stream_drain();
        for (int i = 0; i < 4; i++) begin
            crate_write((i % 2) ? 2'd3 : 2'd0, 25'h100 + 25'(i), 32'h1000_0000 + i, 1'b1);
        end
        wait_stream_drain();

        // crate reads answered by the responder
        crate_read_expect(2'd3, 25'h0AB_CDE0, 1'b1, {7'b0, 25'h0AB_CDE0} ^ RESP_XOR, "read link 3");
        crate_read_expect(2'd0, 25'h1FF_0004, 1'b1, {7'b0, 25'h1FF_0004} ^ RESP_XOR, "read link 0");
        wait_stream_drain();

        // failure paths
        responder_on = 1'b0;
        crate_read_expect(2'd0, 25'h000_0010, 1'b1, BAD_DATA, "timed out read");
        wait_stream_drain();
        reg_read_expect(28'd3, 32'h0000_0001, "status after timeout");
        link_up <= 4'b0011;
        crate_write(2'd3, 25'h000_0020, 32'h5555_5555, 1'b0);
        crate_write(2'd1, 25'h000_0030, 32'hAAAA_AAAA, 1'b0);
        crate_read_expect(2'd1, 25'h000_0040, 1'b0, BAD_DATA, "reserved type read");
        crate_read_expect(2'd2, 25'h000_0050, 1'b0, 32'h0, "bridge none read");
        reg_read_expect(28'd3, 32'h0000_0A01, "status flags");
        reg_write(28'd3, 32'h0000_0F0F);
        reg_read_expect(28'd3, 32'h0, "status after clear");
        reg_read_expect(28'd4, 32'h0000_0003, "link up after drop");

        // room for any stray beat to show
        repeat (20) @(posedge ps_clk);
        if (exp_beats.size() != 0) begin
            $display("%0d expected command beats are still missing", exp_beats.size());
            other_errors++;
        end

        $display("counts: mismatches=%0d timeouts=%0d other=%0d assertion_failures=%0d",
                 mismatches, timeouts, other_errors, dut0.u_checker.fail_count);
        if (mismatches + timeouts + other_errors + dut0.u_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/turf_reg_pkg.sv
verilog/turf_intercon.sv
verilog/turf_id_ctrl.sv
verilog/crate_bridge.sv
verilog/cmd_fifo.sv
verilog/cmd_sender.sv
verilog/turf_reg_top.sv
tb/turf_reg_checker.sv
tb/tb_turf_reg.sv

/* Bender.yml */
package:
  name: turf_reg

sources:
  - files:
      - verilog/turf_reg_pkg.sv
      - verilog/turf_intercon.sv
      - verilog/turf_id_ctrl.sv
      - verilog/crate_bridge.sv
      - verilog/cmd_fifo.sv
      - verilog/cmd_sender.sv
      - verilog/turf_reg_top.sv
  - target: test
    files:
      - tb/turf_reg_checker.sv
      - tb/tb_turf_reg.sv
